/* files.f */
+incdir+hdl
hdl/monitorPkg.sv
hdl/spiFrameIf.sv
hdl/spiFrameFsm.sv
hdl/spiRegisterBank.sv
hdl/intervalTimer.sv
hdl/sequencerMonitorTop.sv
verification/tbClockGen.sv
verification/sequencerMonitorTb.sv

/* hdl/intervalTimer.sv */
`timescale 1ns/100ps
`include "monitorDefs_defs.svh"

module intervalTimer
(
	input  logic clk20mhz,
	input  logic rst,
	input  logic strobe,
	output monitorPkg::usCount_t interval
);

	localparam int unsigned PRE_W = $clog2(`CLK_PER_US);

	logic [`SYNC_STAGES-1:0] strobeSync;
	logic strobePrev;
	logic strobeRise;
	logic armed;
	logic usTick;
	logic [PRE_W-1:0] prescaler;
	monitorPkg::usCount_t usCount;
	monitorPkg::usCount_t usNext;

	// ------------------------------------------------------------
	// synchronizer and registered edge pulse
	always_ff @(posedge clk20mhz)
	begin
		if (rst)
		begin
			strobeSync <= '0;
			strobePrev <= 1'b0;
			strobeRise <= 1'b0;
		end
		else
		begin
			strobeSync <= {strobeSync[`SYNC_STAGES-2:0], strobe};
			strobePrev <= strobeSync[`SYNC_STAGES-1];
			strobeRise <= strobeSync[`SYNC_STAGES-1] & ~strobePrev;
		end
	end

	// count including the current cycle, so N cycles give floor(N / CLK_PER_US)
	assign usTick = (prescaler == PRE_W'(`CLK_PER_US - 1));

	always_comb
	begin
		if (usTick && (usCount != '1))
			usNext = usCount + 32'd1;
		else
			usNext = usCount;
	end

	// ------------------------------------------------------------
	// microsecond counter
	always_ff @(posedge clk20mhz)
	begin
		if (rst)
		begin
			prescaler <= '0;
			usCount <= '0;
			armed <= 1'b0;
			interval <= '0;
		end
		else if (strobeRise)
		begin
			prescaler <= '0;
			usCount <= '0;
			armed <= 1'b1;
			// first edge after reset only starts the count
			if (armed)
				interval <= usNext;
		end
		else
		begin
			prescaler <= usTick ? '0 : prescaler + 1'b1;
			usCount <= usNext;
		end
	end

	assert property (@(posedge clk20mhz) disable iff (rst)
		prescaler < PRE_W'(`CLK_PER_US));

endmodule

/* hdl/monitorDefs_defs.svh */
`ifndef MONITOR_DEFS_SVH
`define MONITOR_DEFS_SVH

// system clock cycles in one microsecond at 20 MHz
`define CLK_PER_US 20

// flip-flops on every asynchronous input
`define SYNC_STAGES 2

// SPI frame layout, address byte then data word
`define ADDR_W 8
`define DATA_W 32
`define FRAME_BITS 40

// register widths
`define CTRL_W 16
`define STATUS_W 8

// fixed identity word for link bring-up
`define ID_WORD 32'hDEEDBEEF

`endif

/* hdl/monitorPkg.sv */
`include "monitorDefs_defs.svh"

package monitorPkg;

	// ------------------------------------------------------------
	// data words
	typedef logic [`DATA_W-1:0] regWord_t;
	typedef logic [31:0] usCount_t;
	typedef logic [`CTRL_W-1:0] ctrlWord_t;
	typedef logic [`STATUS_W-1:0] statusWord_t;

	// ------------------------------------------------------------
	// first frame byte, selects register and direction
	typedef enum logic [`ADDR_W-1:0]
	{
		ADDR_STATUS = 8'd1,
		ADDR_CTRL = 8'd2,
		ADDR_ID = 8'd30,
		ADDR_TNO_TIME = 8'd31,
		ADDR_TNC_TIME = 8'd32,
		ADDR_SCRATCH_RD = 8'd35,
		ADDR_SCRATCH_WR = 8'd36
	} spiAddr_t;

	// frame receiver states
	typedef enum logic [1:0]
	{
		FS_IDLE,
		FS_ADDR,
		FS_DATA,
		FS_DONE
	} frameState_t;

endpackage

/* hdl/sequencerMonitorTop.sv */
`timescale 1ns/100ps
`include "monitorDefs_defs.svh"

module sequencerMonitorTop
(
	input  logic clk20mhz,
	input  logic rst,

	// microcontroller SPI link
	input  logic sclk,
	input  logic mosi,
	input  logic csN,
	output logic miso,

	// board level inputs and relay outputs
	input  logic [`STATUS_W-1:0] statusIn,
	output logic [`CTRL_W-1:0] ctrlOut,

	// timing strobes
	input  logic tnoStrobe,
	input  logic tncStrobe
);

	monitorPkg::usCount_t tnoTime;
	monitorPkg::usCount_t tncTime;

	spiFrameIf frameBus ();

	// ------------------------------------------------------------
	// SPI register link
	spiFrameFsm frameFsm
	(
		.clk20mhz (clk20mhz),
		.rst      (rst),
		.sclk     (sclk),
		.mosi     (mosi),
		.csN      (csN),
		.miso     (miso),
		.frame    (frameBus.fsm)
	);

	spiRegisterBank regBank
	(
		.clk20mhz (clk20mhz),
		.rst      (rst),
		.frame    (frameBus.bank),
		.statusIn (statusIn),
		.tnoTime  (tnoTime),
		.tncTime  (tncTime),
		.ctrlOut  (ctrlOut)
	);

	// ------------------------------------------------------------
	// strobe interval monitors
	intervalTimer tnoTimer
	(
		.clk20mhz (clk20mhz),
		.rst      (rst),
		.strobe   (tnoStrobe),
		.interval (tnoTime)
	);

	intervalTimer tncTimer
	(
		.clk20mhz (clk20mhz),
		.rst      (rst),
		.strobe   (tncStrobe),
		.interval (tncTime)
	);

endmodule

/* hdl/spiFrameFsm.sv */
`timescale 1ns/100ps
`include "monitorDefs_defs.svh"

module spiFrameFsm
(
	input  logic clk20mhz,
	input  logic rst,
	input  logic sclk,
	input  logic mosi,
	input  logic csN,
	output logic miso,
	spiFrameIf.fsm frame
);

	logic [`SYNC_STAGES-1:0] sclkSync;
	logic [`SYNC_STAGES-1:0] csSync;
	logic [`SYNC_STAGES-1:0] mosiSync;
	logic sclkPrev;
	logic csPrev;
	logic sclkRise;
	logic sclkFall;
	logic csRise;
	logic csLow;
	logic mosiBit;
	logic addrDone;
	logic dataDone;
	logic rdLoad;
	logic [5:0] bitCount;
	monitorPkg::frameState_t state;
	monitorPkg::regWord_t shiftIn;
	monitorPkg::regWord_t txShift;

	// ------------------------------------------------------------
	// input synchronizers and edge detection
	always_ff @(posedge clk20mhz)
	begin
		if (rst)
		begin
			sclkSync <= '0;
			csSync <= '1;
			sclkPrev <= 1'b0;
			csPrev <= 1'b1;
		end
		else
		begin
			sclkSync <= {sclkSync[`SYNC_STAGES-2:0], sclk};
			csSync <= {csSync[`SYNC_STAGES-2:0], csN};
			sclkPrev <= sclkSync[`SYNC_STAGES-1];
			csPrev <= csSync[`SYNC_STAGES-1];
		end
	end

	// data line only needs the same latency as sclk
	always_ff @(posedge clk20mhz)
	begin
		mosiSync <= {mosiSync[`SYNC_STAGES-2:0], mosi};
	end

	assign sclkRise = sclkSync[`SYNC_STAGES-1] & ~sclkPrev;
	assign sclkFall = ~sclkSync[`SYNC_STAGES-1] & sclkPrev;
	assign csRise = csSync[`SYNC_STAGES-1] & ~csPrev;
	assign csLow = ~csSync[`SYNC_STAGES-1];
	assign mosiBit = mosiSync[`SYNC_STAGES-1];

	assign addrDone = (state == monitorPkg::FS_ADDR) && sclkRise && !csRise
		&& (bitCount == 6'(`ADDR_W - 1));
	assign dataDone = (state == monitorPkg::FS_DATA) && sclkRise && !csRise
		&& (bitCount == 6'(`FRAME_BITS - 1));

	// ------------------------------------------------------------
	// frame control
	always_ff @(posedge clk20mhz)
	begin
		if (rst)
		begin
			state <= monitorPkg::FS_IDLE;
			bitCount <= '0;
			frame.addrValid <= 1'b0;
			frame.wrStrobe <= 1'b0;
			rdLoad <= 1'b0;
			miso <= 1'b1;
		end
		else
		begin
			frame.addrValid <= addrDone;
			frame.wrStrobe <= dataDone && csLow;
			// bank answers one cycle after addrValid
			rdLoad <= frame.addrValid;
			if (csRise)
			begin
				// deselect drops whatever frame was in progress
				state <= monitorPkg::FS_IDLE;
				bitCount <= '0;
				miso <= 1'b1;
			end
			else
			begin
				case (state)
					monitorPkg::FS_IDLE:
					begin
						bitCount <= '0;
						if (csLow)
							state <= monitorPkg::FS_ADDR;
					end
					monitorPkg::FS_ADDR:
					begin
						if (sclkRise)
							bitCount <= bitCount + 6'd1;
						if (addrDone)
							state <= monitorPkg::FS_DATA;
					end
					monitorPkg::FS_DATA:
					begin
						if (sclkRise)
							bitCount <= bitCount + 6'd1;
						else if (sclkFall)
							miso <= txShift[`DATA_W-1];
						if (dataDone)
							state <= monitorPkg::FS_DONE;
					end
					default:
					begin
						// hold until csN goes high
					end
				endcase
			end
		end
	end

	// ------------------------------------------------------------
	// shift registers
	always_ff @(posedge clk20mhz)
	begin
		if (sclkRise)
			shiftIn <= {shiftIn[`DATA_W-2:0], mosiBit};
		if (addrDone)
			frame.addr <= monitorPkg::spiAddr_t'({shiftIn[`ADDR_W-2:0], mosiBit});
		if (dataDone)
			frame.wrData <= {shiftIn[`DATA_W-2:0], mosiBit};
		if (rdLoad)
			txShift <= frame.rdData;
		else if ((state == monitorPkg::FS_DATA) && sclkFall)
			txShift <= {txShift[`DATA_W-2:0], 1'b0};
	end

	assert property (@(posedge clk20mhz) disable iff (rst)
		bitCount <= 6'(`FRAME_BITS));

	assert property (@(posedge clk20mhz) disable iff (rst)
		frame.wrStrobe |-> (state == monitorPkg::FS_DONE));

endmodule

/* hdl/spiFrameIf.sv */
`timescale 1ns/100ps

interface spiFrameIf;

	// address byte, valid for one cycle after the eighth bit
	monitorPkg::spiAddr_t addr;
	logic addrValid;

	// write word, pulsed once per completed frame
	monitorPkg::regWord_t wrData;
	logic wrStrobe;

	// read word returned by the bank the cycle after addrValid
	monitorPkg::regWord_t rdData;

	modport fsm
	(
		output addr, addrValid, wrData, wrStrobe,
		input rdData
	);

	modport bank
	(
		input addr, addrValid, wrData, wrStrobe,
		output rdData
	);

endinterface

/* hdl/spiRegisterBank.sv */
`timescale 1ns/100ps
`include "monitorDefs_defs.svh"

module spiRegisterBank
(
	input  logic clk20mhz,
	input  logic rst,
	spiFrameIf.bank frame,
	input  monitorPkg::statusWord_t statusIn,
	input  monitorPkg::usCount_t tnoTime,
	input  monitorPkg::usCount_t tncTime,
	output monitorPkg::ctrlWord_t ctrlOut
);

	monitorPkg::regWord_t scratchReg;
	monitorPkg::regWord_t readValue;
	monitorPkg::statusWord_t statusMeta;
	monitorPkg::statusWord_t statusSync;

	// ------------------------------------------------------------
	// writable registers
	always_ff @(posedge clk20mhz)
	begin
		if (rst)
		begin
			ctrlOut <= '0;
			scratchReg <= '0;
		end
		else if (frame.wrStrobe)
		begin
			case (frame.addr)
				monitorPkg::ADDR_CTRL:
					ctrlOut <= frame.wrData[`CTRL_W-1:0];
				monitorPkg::ADDR_SCRATCH_WR:
					scratchReg <= frame.wrData;
				default:
				begin
					// read-only or unknown address
				end
			endcase
		end
	end

	// level inputs are asynchronous to clk20mhz
	always_ff @(posedge clk20mhz)
	begin
		statusMeta <= statusIn;
		statusSync <= statusMeta;
	end

	// ------------------------------------------------------------
	// read multiplexer
	always_comb
	begin
		case (frame.addr)
			monitorPkg::ADDR_STATUS:
				readValue = {{(`DATA_W - `STATUS_W){1'b0}}, statusSync};
			monitorPkg::ADDR_ID:
				readValue = `ID_WORD;
			monitorPkg::ADDR_TNO_TIME:
				readValue = tnoTime;
			monitorPkg::ADDR_TNC_TIME:
				readValue = tncTime;
			monitorPkg::ADDR_SCRATCH_RD:
				readValue = scratchReg;
			default:
				readValue = '0;
		endcase
	end

	// sampled once per frame, held while the word shifts out
	always_ff @(posedge clk20mhz)
	begin
		if (frame.addrValid)
			frame.rdData <= readValue;
	end

	// address and write strobes come from different frame phases
	assert property (@(posedge clk20mhz) disable iff (rst)
		!(frame.wrStrobe && frame.addrValid));

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f files.f --top-module sequencerMonitorTb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verification/sequencerMonitorTb.sv */
`timescale 1ns/100ps
`include "monitorDefs_defs.svh"

module sequencerMonitorTb;

	localparam int CLK_NS = 50;
	localparam int SCRATCH_WORDS = 20;
	localparam int STATUS_READS = 6;
	localparam int GAP_ROUNDS = 4;
	localparam int MIN_GAP = 40;
	localparam int MAX_GAP = 3000;
	localparam int FRAME_COUNT = 2 + 3 + 2 * SCRATCH_WORDS + STATUS_READS + 2
		+ 2 * GAP_ROUNDS + 3;
	localparam int WATCHDOG_CYCLES = 2 * (FRAME_COUNT * `FRAME_BITS * 8
		+ 2 * GAP_ROUNDS * MAX_GAP);
	localparam logic [7:0] ADDR_UNKNOWN = 8'd99;
	localparam int KIND_WORD = 0;
	localparam int KIND_CTRL = 1;
	localparam int KIND_INTERVAL = 2;

	logic clk20mhz;
	logic rst;
	logic sclk;
	logic mosi;
	logic csN;
	logic miso;
	logic tnoStrobe;
	logic tncStrobe;
	monitorPkg::statusWord_t statusIn;
	monitorPkg::ctrlWord_t ctrlOut;

	// register model of the board as the microcontroller sees it
	monitorPkg::ctrlWord_t modelCtrl;
	monitorPkg::regWord_t modelScratch;
	monitorPkg::statusWord_t modelStatus;
	int modelTnoGap;
	int modelTncGap;

	// results waiting for the compare process
	int kindQ[$];
	logic [7:0] addrQ[$];
	monitorPkg::regWord_t gotQ[$];
	monitorPkg::regWord_t expQ[$];
	int checkCount;
	int errorCount;

	tbClockGen clockGen
	(
		.clk (clk20mhz)
	);

	sequencerMonitorTop dut
	(
		.clk20mhz  (clk20mhz),
		.rst       (rst),
		.sclk      (sclk),
		.mosi      (mosi),
		.csN       (csN),
		.miso      (miso),
		.statusIn  (statusIn),
		.ctrlOut   (ctrlOut),
		.tnoStrobe (tnoStrobe),
		.tncStrobe (tncStrobe)
	);

	// ------------------------------------------------------------
	// reference model of the read multiplexer
	function automatic monitorPkg::regWord_t expectedRead(input logic [7:0] addr);
		case (addr)
			monitorPkg::ADDR_STATUS:
				return {24'd0, modelStatus};
			monitorPkg::ADDR_ID:
				return 32'hDEEDBEEF;
			monitorPkg::ADDR_TNO_TIME:
				return monitorPkg::usCount_t'(modelTnoGap / `CLK_PER_US);
			monitorPkg::ADDR_TNC_TIME:
				return monitorPkg::usCount_t'(modelTncGap / `CLK_PER_US);
			monitorPkg::ADDR_SCRATCH_RD:
				return modelScratch;
			// write-only and unknown addresses
			default:
				return '0;
		endcase
	endfunction

	task automatic checkWord(input monitorPkg::regWord_t got, input monitorPkg::regWord_t exp,
		input logic [7:0] addr);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail at %0t: read of address %0d gave %h, expected %h",
				$time, addr, got, exp);
		end
	endtask

	task automatic checkCtrl(input monitorPkg::ctrlWord_t got, input monitorPkg::ctrlWord_t exp,
		input logic [7:0] addr);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail at %0t: ctrlOut is %h after frame to address %0d, expected %h",
				$time, got, addr, exp);
		end
	endtask

	task automatic checkInterval(input monitorPkg::usCount_t got,
		input monitorPkg::usCount_t exp, input logic [7:0] addr);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Fail at %0t: interval at address %0d is %0d us, expected %0d us",
				$time, addr, got, exp);
		end
	endtask

	task automatic recordResult(input int kind, input logic [7:0] addr,
		input monitorPkg::regWord_t got, input monitorPkg::regWord_t exp);
		kindQ.push_back(kind);
		addrQ.push_back(addr);
		gotQ.push_back(got);
		expQ.push_back(exp);
	endtask

	// ------------------------------------------------------------
	// SPI master, mode 0, half period of 4 clocks
	task automatic spiTransfer(input logic [7:0] addr, input monitorPkg::regWord_t data,
		input int bits, output monitorPkg::regWord_t rdWord);
		logic [`FRAME_BITS-1:0] frameBits;
		frameBits = {addr, data};
		rdWord = '0;
		@(posedge clk20mhz);
		csN <= 1'b0;
		repeat (4) @(posedge clk20mhz);
		for (int i = 0; i < bits; i++)
		begin
			sclk <= 1'b0;
			mosi <= frameBits[`FRAME_BITS-1-i];
			repeat (3) @(posedge clk20mhz);
			// miso is settled by now, sample away from the clock edge
			@(negedge clk20mhz);
			if (i >= `ADDR_W)
				rdWord[`FRAME_BITS-1-i] = miso;
			@(posedge clk20mhz);
			sclk <= 1'b1;
			repeat (4) @(posedge clk20mhz);
		end
		sclk <= 1'b0;
		repeat (4) @(posedge clk20mhz);
		csN <= 1'b1;
		repeat (8) @(posedge clk20mhz);
	endtask

	task automatic readRegister(input logic [7:0] addr, input int kind);
		monitorPkg::regWord_t got;
		// data bits of a read are don't care
		spiTransfer(addr, $urandom(), `FRAME_BITS, got);
		recordResult(kind, addr, got, expectedRead(addr));
	endtask

	task automatic writeRegister(input logic [7:0] addr, input monitorPkg::regWord_t data,
		input int bits);
		monitorPkg::regWord_t unused;
		spiTransfer(addr, data, bits, unused);
		// a frame cut short writes nothing
		if (bits == `FRAME_BITS)
		begin
			if (addr == monitorPkg::ADDR_CTRL)
				modelCtrl = data[`CTRL_W-1:0];
			if (addr == monitorPkg::ADDR_SCRATCH_WR)
				modelScratch = data;
		end
		@(negedge clk20mhz);
		recordResult(KIND_CTRL, addr, 32'(ctrlOut), 32'(modelCtrl));
	endtask

	task automatic setStrobe(input int which, input logic level);
		if (which == 0)
			tnoStrobe <= level;
		else
			tncStrobe <= level;
	endtask

	// two rising edges exactly gap cycles apart
	task automatic pulsePair(input int which, input int gap);
		@(posedge clk20mhz);
		setStrobe(which, 1'b1);
		repeat (3) @(posedge clk20mhz);
		setStrobe(which, 1'b0);
		repeat (gap - 3) @(posedge clk20mhz);
		setStrobe(which, 1'b1);
		repeat (3) @(posedge clk20mhz);
		setStrobe(which, 1'b0);
		repeat (8) @(posedge clk20mhz);
		if (which == 0)
			modelTnoGap = gap;
		else
			modelTncGap = gap;
	endtask

	// ------------------------------------------------------------
	// compare process
	initial
	begin
		int kind;
		logic [7:0] addr;
		monitorPkg::regWord_t got;
		monitorPkg::regWord_t exp;
		forever
		begin
			@(negedge clk20mhz);
			while (kindQ.size() > 0)
			begin
				kind = kindQ.pop_front();
				addr = addrQ.pop_front();
				got = gotQ.pop_front();
				exp = expQ.pop_front();
				case (kind)
					KIND_CTRL:
						checkCtrl(got[`CTRL_W-1:0], exp[`CTRL_W-1:0], addr);
					KIND_INTERVAL:
						checkInterval(got, exp, addr);
					default:
						checkWord(got, exp, addr);
				endcase
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_NS);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	// ------------------------------------------------------------
	// stimulus
	initial
	begin
		monitorPkg::regWord_t word;
		int gap;
		rst <= 1'b1;
		sclk <= 1'b0;
		mosi <= 1'b0;
		csN <= 1'b1;
		statusIn <= '0;
		tnoStrobe <= 1'b0;
		tncStrobe <= 1'b0;
		void'($urandom(46));
		modelCtrl = '0;
		modelScratch = '0;
		modelStatus = '0;
		modelTnoGap = 0;
		modelTncGap = 0;
		checkCount = 0;
		errorCount = 0;
		repeat (5) @(posedge clk20mhz);
		rst <= 1'b0;
		repeat (2) @(posedge clk20mhz);

		// nothing measured yet
		readRegister(monitorPkg::ADDR_TNO_TIME, KIND_INTERVAL);
		readRegister(monitorPkg::ADDR_TNC_TIME, KIND_INTERVAL);
		readRegister(monitorPkg::ADDR_ID, KIND_WORD);
		readRegister(ADDR_UNKNOWN, KIND_WORD);

		writeRegister(monitorPkg::ADDR_CTRL, $urandom(), `FRAME_BITS);
		writeRegister(monitorPkg::ADDR_SCRATCH_WR, $urandom(), `FRAME_BITS);
		writeRegister(ADDR_UNKNOWN, $urandom(), `FRAME_BITS);

		for (int k = 0; k < SCRATCH_WORDS; k++)
		begin
			writeRegister(monitorPkg::ADDR_SCRATCH_WR, $urandom(), `FRAME_BITS);
			readRegister(monitorPkg::ADDR_SCRATCH_RD, KIND_WORD);
		end

		for (int k = 0; k < STATUS_READS; k++)
		begin
			word = $urandom();
			@(posedge clk20mhz);
			statusIn <= word[`STATUS_W-1:0];
			modelStatus = word[`STATUS_W-1:0];
			repeat (4) @(posedge clk20mhz);
			readRegister(monitorPkg::ADDR_STATUS, KIND_WORD);
		end

		// first round sits on a microsecond boundary
		for (int k = 0; k < GAP_ROUNDS; k++)
		begin
			gap = (k == 0) ? 100 : int'($urandom_range(MAX_GAP, MIN_GAP));
			pulsePair(0, gap);
			gap = (k == 0) ? 99 : int'($urandom_range(MAX_GAP, MIN_GAP));
			pulsePair(1, gap);
			readRegister(monitorPkg::ADDR_TNO_TIME, KIND_INTERVAL);
			readRegister(monitorPkg::ADDR_TNC_TIME, KIND_INTERVAL);
		end

		// frames dropped after 20 bits
		writeRegister(monitorPkg::ADDR_CTRL, {16'd0, ~modelCtrl}, 20);
		writeRegister(monitorPkg::ADDR_SCRATCH_WR, ~modelScratch, 20);
		readRegister(monitorPkg::ADDR_SCRATCH_RD, KIND_WORD);

		while (kindQ.size() != 0)
			@(negedge clk20mhz);
		@(negedge clk20mhz);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* verification/tbClockGen.sv */
`timescale 1ns/100ps

module tbClockGen
(
	output logic clk
);

	// 20 MHz system clock, 50 ns period
	localparam int HALF_NS = 25;

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_NS clk = ~clk;
	end

endmodule
